//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_nd_addr_gen
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# Pass only when the testbench prints its pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- src/bit_scan.sv
`timescale 1ns/10ps
`default_nettype none

// First set bit search from either end of a vector
module bit_scan #(
	parameter int W = 2,
	parameter bit FROM_MSB = 1'b0
) (
	input  wire logic [W-1:0] i_bits,
	output logic [W:0]        o_detect,
	output logic [W-1:0]      o_prefix
);

	// Position visited at scan step k
	function automatic int scan_pos(input int k);
		return FROM_MSB ? (W - 1 - k) : k;
	endfunction

	// ==============================
	// Scan chain
	// ==============================

	always_comb begin : scan
		logic clear;
		// Nothing found yet
		clear = 1'b1;
		for (int k = 0; k < W; k++) begin
			// Hit is the first set bit seen
			o_detect[scan_pos(k)] = clear & i_bits[scan_pos(k)];
			// Positions passed over before the hit
			o_prefix[scan_pos(k)] = clear & ~i_bits[scan_pos(k)];
			clear = clear & ~i_bits[scan_pos(k)];
		end
		// Extra bit flags an all-zero input
		o_detect[W] = clear;
	end

endmodule

`default_nettype wire

//--- src/nd_adder.sv
`timescale 1ns/10ps
`default_nettype none

// Next step of the loop nest, odometer style
module nd_adder (
	input  wire logic             i_clk,
	input  wire logic             i_reset,
	input  wire nd_pkg::idx_vec_t i_idx,
	input  wire nd_pkg::idx_vec_t i_cnt,
	input  wire nd_pkg::idx_vec_t i_beg,
	input  wire nd_pkg::idx_vec_t i_end,
	input  wire nd_pkg::idx_vec_t i_stride,
	output nd_pkg::idx_vec_t      o_nxt_idx,
	output nd_pkg::idx_vec_t      o_nxt_cnt,
	output logic                  o_carry
);
	import nd_pkg::*;

	idx_vec_t added;
	// Bit b is dimension DIM-1-b, innermost at the LSB
	logic [DIM-1:0] no_wrap;
	logic [DIM:0]   adv_sel;
	logic [DIM-1:0] wrap_sel;
	// Bit i is dimension i, innermost at the MSB
	logic [DIM-1:0] not_beg;
	logic [DIM-1:0] beg_run;
	logic [DIM-1:0] wrap_dim;

	// ==============================
	// Compare
	// ==============================

	always_comb begin
		for (int i = 0; i < DIM; i++) begin
			added[i] = i_idx[i] + i_stride[i];
			// Stepping this dimension would not reach its end
			no_wrap[DIM-1-i] = (added[i] != i_end[i]);
			not_beg[i] = (i_idx[i] != i_beg[i]);
			wrap_dim[i] = wrap_sel[DIM-1-i];
		end
	end

	// Innermost dimension that can still step, inner ones wrap
	bit_scan #(.W(DIM), .FROM_MSB(1'b0)) u_adv (
		.i_bits   (no_wrap),
		.o_detect (adv_sel),
		.o_prefix (wrap_sel)
	);

	// Run of inner dimensions sitting at their begin value
	bit_scan #(.W(DIM), .FROM_MSB(1'b1)) u_beg (
		.i_bits   (not_beg),
		.o_detect (),
		.o_prefix (beg_run)
	);

	// ==============================
	// Select
	// ==============================

	// Every dimension wrapped, so the current step is the last
	assign o_carry = adv_sel[DIM];

	always_comb begin
		for (int i = 0; i < DIM; i++) begin
			if (wrap_sel[DIM-1-i]) begin
				o_nxt_idx[i] = i_beg[i];
				o_nxt_cnt[i] = '0;
			end else if (adv_sel[DIM-1-i]) begin
				o_nxt_idx[i] = added[i];
				o_nxt_cnt[i] = i_cnt[i] + i_stride[i];
			end else begin
				// Outer dimensions keep their place
				o_nxt_idx[i] = i_idx[i];
				o_nxt_cnt[i] = i_cnt[i];
			end
		end
	end

	// New tuple after a step restarts every wrapped dimension at begin
	a_wrap_restart: assert property (@(posedge i_clk) disable iff (i_reset)
		($changed(i_idx) && !$past(o_carry)) |-> (($past(wrap_dim) & ~beg_run) == '0))
		else $error("wrapped dimension did not restart at begin");

endmodule

`default_nettype wire

//--- src/nd_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

// N-dimensional address generator
module nd_addr_gen (
	input  wire logic                i_clk,
	input  wire logic                i_reset,

	// Configuration
	input  wire logic                i_cfg_valid,
	output logic                     o_cfg_ready,
	input  wire nd_pkg::idx_vec_t    i_beg,
	input  wire nd_pkg::idx_vec_t    i_end,
	input  wire nd_pkg::idx_vec_t    i_stride,
	input  wire nd_pkg::shuf_vec_t   i_shuf_idx,
	input  wire nd_pkg::shuf_vec_t   i_shuf_cnt,
	input  wire nd_pkg::coord_vec_t  i_base,

	// Coordinates out
	output logic                     o_valid,
	input  wire logic                i_ready,
	output nd_pkg::coord_vec_t       o_coord,
	output logic                     o_last
);

	// ==============================
	// Internal links
	// ==============================

	nd_cfg_if cfg_if ();
	nd_step_if step_if ();

	// Configuration from the plain ports
	assign cfg_if.valid = i_cfg_valid;
	assign cfg_if.beg = i_beg;
	assign cfg_if.fin = i_end;
	assign cfg_if.stride = i_stride;
	assign cfg_if.shuf_idx = i_shuf_idx;
	assign cfg_if.shuf_cnt = i_shuf_cnt;
	assign cfg_if.base = i_base;
	assign o_cfg_ready = cfg_if.ready;

	// Loop walker
	nd_loop_ctrl u_loop_ctrl (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.cfg     (cfg_if.ctrl),
		.step    (step_if.src)
	);

	// Coordinate mapping and output register
	nd_shuf_accum u_shuf_accum (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.cfg     (cfg_if.accum),
		.step    (step_if.dst),
		.o_valid (o_valid),
		.i_ready (i_ready),
		.o_coord (o_coord),
		.o_last  (o_last)
	);

endmodule

`default_nettype wire

//--- src/nd_if.sv
`timescale 1ns/10ps
`default_nettype none

// Loop nest configuration, held steady for the whole walk
interface nd_cfg_if;
	import nd_pkg::*;

	// Handshake
	logic valid;
	logic ready;

	// Loop bounds, end value is exclusive
	idx_vec_t beg;
	idx_vec_t fin;
	idx_vec_t stride;

	// Coordinate routing and offsets
	shuf_vec_t shuf_idx;
	shuf_vec_t shuf_cnt;
	coord_vec_t base;

	// Loop controller takes the bounds and grants the transfer
	modport ctrl (
		input  valid,
		input  beg,
		input  fin,
		input  stride,
		output ready
	);

	// Accumulator only reads the routing fields
	modport accum (
		input shuf_idx,
		input shuf_cnt,
		input base
	);
endinterface

// One loop step, index and offset-free count tuples
interface nd_step_if;
	import nd_pkg::*;

	logic valid;
	logic ready;
	idx_vec_t idx;
	idx_vec_t cnt;
	logic last;

	modport src (output valid, output idx, output cnt, output last, input ready);
	modport dst (input valid, input idx, input cnt, input last, output ready);
endinterface

`default_nettype wire

//--- src/nd_loop_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

// Loop nest walker, one step per accepted handshake
module nd_loop_ctrl (
	input wire logic i_clk,
	input wire logic i_reset,
	nd_cfg_if.ctrl   cfg,
	nd_step_if.src   step
);
	import nd_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_RUN
	} state_t;

	state_t state;

	// Captured bounds
	idx_vec_t beg_q;
	idx_vec_t end_q;
	idx_vec_t stride_q;

	// Current tuple
	idx_vec_t idx_q;
	idx_vec_t cnt_q;

	// Adder results
	idx_vec_t nxt_idx;
	idx_vec_t nxt_cnt;
	logic carry;

	logic cfg_fire;
	logic step_fire;

	// ==============================
	// Handshakes
	// ==============================

	// New configuration only between walks
	assign cfg.ready = (state == ST_IDLE);
	assign cfg_fire = cfg.valid & cfg.ready;

	assign step.valid = (state == ST_RUN);
	assign step_fire = step.valid & step.ready;

	// Payload comes straight from the tuple registers
	assign step.idx = idx_q;
	assign step.cnt = cnt_q;
	assign step.last = carry;

	// Next tuple
	nd_adder u_adder (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_idx     (idx_q),
		.i_cnt     (cnt_q),
		.i_beg     (beg_q),
		.i_end     (end_q),
		.i_stride  (stride_q),
		.o_nxt_idx (nxt_idx),
		.o_nxt_cnt (nxt_cnt),
		.o_carry   (carry)
	);

	// ==============================
	// State
	// ==============================

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (cfg_fire) state <= ST_RUN;
				// Leave once the last step is taken
				ST_RUN: if (step_fire && carry) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Bounds and tuple
	always_ff @(posedge i_clk) begin
		if (cfg_fire) begin
			beg_q <= cfg.beg;
			end_q <= cfg.fin;
			stride_q <= cfg.stride;
			// Walk starts at begin with zero counts
			idx_q <= cfg.beg;
			cnt_q <= '0;
		end else if (step_fire) begin
			idx_q <= nxt_idx;
			cnt_q <= nxt_cnt;
		end
	end

	// Step valid only rises right after a configuration
	a_valid_start: assert property (@(posedge i_clk) disable iff (i_reset)
		$rose(step.valid) |-> $past(cfg_fire))
		else $error("step valid rose without a configuration");

	// Stalled step keeps its payload
	a_step_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		(step.valid && !step.ready) |=>
			(step.valid && $stable(step.idx) && $stable(step.cnt) && $stable(step.last)))
		else $error("step payload changed while stalled");

endmodule

`default_nettype wire

//--- src/nd_pkg.sv
`default_nettype none

package nd_pkg;

	// ==============================
	// Sizes
	// ==============================

	// Width of one index, count, base or coordinate
	localparam int BW = 8;

	// Loop nest depth, dimension DIM-1 is innermost
	localparam int DIM = 2;

	// Number of coordinates leaving the accumulator
	localparam int DIM_OUT = 2;

	// Width of one shuffle selector
	localparam int SHUF_BW = $clog2(DIM_OUT);

	// ==============================
	// Types
	// ==============================

	// One loop value
	typedef logic [BW-1:0] idx_t;

	// One value per loop dimension
	typedef idx_t [DIM-1:0] idx_vec_t;

	// One value per output coordinate
	typedef idx_t [DIM_OUT-1:0] coord_vec_t;

	// Target coordinate of each loop dimension
	typedef logic [DIM-1:0][SHUF_BW-1:0] shuf_vec_t;

endpackage

`default_nettype wire

//--- src/nd_shuf_accum.sv
`timescale 1ns/10ps
`default_nettype none

// Index and count routing to output coordinates, plus base
module nd_shuf_accum (
	input  wire logic      i_clk,
	input  wire logic      i_reset,
	nd_cfg_if.accum        cfg,
	nd_step_if.dst         step,
	output logic           o_valid,
	input  wire logic      i_ready,
	output nd_pkg::coord_vec_t o_coord,
	output logic           o_last
);
	import nd_pkg::*;

	// Combinational coordinate sums
	coord_vec_t sum;
	logic step_fire;

	// ==============================
	// Accumulate
	// ==============================

	always_comb begin
		for (int k = 0; k < DIM_OUT; k++) begin
			// Start from the coordinate offset
			sum[k] = cfg.base[k];
			for (int j = 0; j < DIM; j++) begin
				// Index of dimension j lands here
				if (cfg.shuf_idx[j] == SHUF_BW'(k)) begin
					sum[k] = sum[k] + step.idx[j];
				end
				// Count of dimension j lands here
				if (cfg.shuf_cnt[j] == SHUF_BW'(k)) begin
					sum[k] = sum[k] + step.cnt[j];
				end
			end
		end
	end

	// ==============================
	// Output stage
	// ==============================

	// Accept while the stage is empty or draining
	assign step.ready = i_ready | ~o_valid;
	assign step_fire = step.valid & step.ready;

	// Control
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_valid <= 1'b0;
			o_last <= 1'b0;
		end else if (step.ready) begin
			o_valid <= step.valid;
			o_last <= step.valid & step.last;
		end
	end

	// Payload
	always_ff @(posedge i_clk) begin
		if (step_fire) begin
			o_coord <= sum;
		end
	end

	// Back-pressure holds the item in place
	a_out_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_valid && !i_ready) |=> (o_valid && $stable(o_coord) && $stable(o_last)))
		else $error("output item changed while stalled");

endmodule

`default_nettype wire

//--- tb.f
src/nd_pkg.sv
src/nd_if.sv
src/bit_scan.sv
src/nd_adder.sv
src/nd_loop_ctrl.sv
src/nd_shuf_accum.sv
src/nd_addr_gen.sv
verif/tb_clock.sv
verif/tb_nd_addr_gen.sv

//--- verif/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

// Free-running testbench clock and power-on reset
module tb_clock #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 3,
	parameter int DRIVE_DELAY = 2
) (
	output logic o_clk,
	output logic o_reset
);

	// Square wave, rising edge every PERIOD_NS
	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// Reset held over the first edges, released just after an edge
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#(DRIVE_DELAY) o_reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- verif/tb_nd_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

// Table-driven testbench for the address generator
module tb_nd_addr_gen;
	import nd_pkg::*;

	localparam int NUM_ROWS = 6;
	// Cycles allowed for any single wait
	localparam int TIMEOUT = 200;
	localparam int DRIVE_DELAY = 2;

	logic clk;
	logic reset;

	// DUT inputs
	logic cfg_valid;
	idx_vec_t beg;
	idx_vec_t fin;
	idx_vec_t stride;
	shuf_vec_t shuf_idx;
	shuf_vec_t shuf_cnt;
	coord_vec_t base;
	logic ready;

	// DUT outputs
	logic cfg_ready;
	logic valid;
	coord_vec_t coord;
	logic last;

	// ==============================
	// Stimulus table
	// ==============================

	string t_name [NUM_ROWS];
	idx_vec_t t_beg [NUM_ROWS];
	idx_vec_t t_end [NUM_ROWS];
	idx_vec_t t_stride [NUM_ROWS];
	shuf_vec_t t_shuf_idx [NUM_ROWS];
	shuf_vec_t t_shuf_cnt [NUM_ROWS];
	coord_vec_t t_base [NUM_ROWS];
	int t_items [NUM_ROWS];

	// Expected items of the walk in progress
	coord_vec_t exp_coord [$];
	logic exp_last [$];

	tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(3), .DRIVE_DELAY(DRIVE_DELAY)) u_clock (
		.o_clk   (clk),
		.o_reset (reset)
	);

	nd_addr_gen dut_i (
		.i_clk       (clk),
		.i_reset     (reset),
		.i_cfg_valid (cfg_valid),
		.o_cfg_ready (cfg_ready),
		.i_beg       (beg),
		.i_end       (fin),
		.i_stride    (stride),
		.i_shuf_idx  (shuf_idx),
		.i_shuf_cnt  (shuf_cnt),
		.i_base      (base),
		.o_valid     (valid),
		.i_ready     (ready),
		.o_coord     (coord),
		.o_last      (last)
	);

	// Wrong value with both sides shown
	task automatic report_mismatch(input string name, input string what,
		input int expected, input int actual);
		$display("ERR %s %s expected %0h actual %0h", name, what, expected, actual);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// Inputs change and outputs are read a little after the edge
	task automatic next_cycle();
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	// One table row with dimension 0 as the outer loop
	task automatic add_row(input int row, input string name,
		input int b0, input int b1, input int e0, input int e1,
		input int s0, input int s1, input int si0, input int si1,
		input int sc0, input int sc1, input int base0, input int base1,
		input int items);
		t_name[row] = name;
		t_beg[row][0] = idx_t'(b0);
		t_beg[row][1] = idx_t'(b1);
		t_end[row][0] = idx_t'(e0);
		t_end[row][1] = idx_t'(e1);
		t_stride[row][0] = idx_t'(s0);
		t_stride[row][1] = idx_t'(s1);
		t_shuf_idx[row][0] = SHUF_BW'(si0);
		t_shuf_idx[row][1] = SHUF_BW'(si1);
		t_shuf_cnt[row][0] = SHUF_BW'(sc0);
		t_shuf_cnt[row][1] = SHUF_BW'(sc1);
		t_base[row][0] = idx_t'(base0);
		t_base[row][1] = idx_t'(base1);
		t_items[row] = items;
	endtask

	task automatic load_table();
		// Row, name, begin, end, stride, index and count targets, base, items
		add_row(0, "unit_identity", 0, 0, 3, 4, 1, 1, 0, 1, 0, 1, 0, 0, 12);
		add_row(1, "stride_offset", 2, 5, 8, 11, 2, 3, 0, 1, 0, 1, 10, 20, 6);
		add_row(2, "crossed", 1, 3, 4, 7, 1, 2, 1, 0, 0, 1, 100, 200, 6);
		add_row(3, "same_coord_wrap", 200, 100, 220, 130, 5, 10, 0, 0, 0, 0, 250, 7, 12);
		add_row(4, "single_item", 7, 9, 8, 10, 1, 1, 0, 1, 1, 0, 1, 2, 1);
		add_row(5, "shared_target", 0, 0, 4, 6, 1, 2, 1, 1, 0, 0, 0, 255, 12);
	endtask

	// ==============================
	// Reference model
	// ==============================

	// Plain nested loops with the innermost dimension fastest
	task automatic build_model(input int row);
		int ix [DIM];
		int cx [DIM];
		int acc;
		coord_vec_t c;
		exp_coord.delete();
		exp_last.delete();
		for (int i0 = t_beg[row][0]; i0 < t_end[row][0]; i0 += t_stride[row][0]) begin
			for (int i1 = t_beg[row][1]; i1 < t_end[row][1]; i1 += t_stride[row][1]) begin
				ix[0] = i0;
				ix[1] = i1;
				// Counts are offset-free
				for (int j = 0; j < DIM; j++) begin
					cx[j] = ix[j] - int'(t_beg[row][j]);
				end
				for (int k = 0; k < DIM_OUT; k++) begin
					acc = int'(t_base[row][k]);
					for (int j = 0; j < DIM; j++) begin
						if (int'(t_shuf_idx[row][j]) == k) acc += ix[j];
						if (int'(t_shuf_cnt[row][j]) == k) acc += cx[j];
					end
					// Coordinates wrap at the word width
					c[k] = idx_t'(acc % (1 << BW));
				end
				exp_coord.push_back(c);
				exp_last.push_back(1'b0);
			end
		end
		// Only the final item carries last
		if (exp_last.size() > 0) exp_last[exp_last.size() - 1] = 1'b1;
		assert (exp_coord.size() == t_items[row])
			else report_mismatch(t_name[row], "item count", t_items[row], exp_coord.size());
	endtask

	// ==============================
	// Sequencing
	// ==============================

	task automatic wait_reset_done();
		int cycles;
		cycles = 0;
		next_cycle();
		while (reset) begin
			assert (cycles < TIMEOUT) else report_problem("reset was never released");
			next_cycle();
			cycles++;
		end
		assert (!valid && !last) else report_problem("output not idle after reset");
		assert (cfg_ready) else report_problem("o_cfg_ready low after reset");
	endtask

	// Between walks no item may leave
	task automatic wait_cfg_ready();
		int cycles;
		cycles = 0;
		assert (!valid) else report_problem("extra output item after the walk");
		while (!cfg_ready) begin
			assert (cycles < TIMEOUT) else report_problem("timed out waiting for o_cfg_ready");
			next_cycle();
			cycles++;
			assert (!valid) else report_problem("extra output item after the walk");
		end
	endtask

	task automatic run_row(input int row);
		int got;
		int cycles;
		logic stall;
		coord_vec_t held_coord;
		logic held_last;
		build_model(row);
		wait_cfg_ready();
		// Fields stay put for the whole walk
		beg = t_beg[row];
		fin = t_end[row];
		stride = t_stride[row];
		shuf_idx = t_shuf_idx[row];
		shuf_cnt = t_shuf_cnt[row];
		base = t_base[row];
		cfg_valid = 1'b1;
		next_cycle();
		cfg_valid = 1'b0;
		got = 0;
		cycles = 0;
		stall = 1'b0;
		held_coord = '0;
		held_last = 1'b0;
		while (got < exp_coord.size()) begin
			assert (cycles < TIMEOUT) else report_problem("timed out waiting for an output item");
			// Held item from the previous cycle
			if (stall) begin
				assert (valid && coord == held_coord && last == held_last)
					else report_mismatch(t_name[row], "stalled item", int'(held_coord), int'(coord));
			end
			// Last step not yet taken by the output stage
			if (got + int'(valid) < exp_coord.size()) begin
				assert (!cfg_ready) else report_problem("o_cfg_ready high during a walk");
			end
			// Back-pressure about one cycle in four
			ready = ($urandom % 4) != 0;
			if (valid && ready) begin
				assert (coord == exp_coord[got])
					else report_mismatch(t_name[row], "o_coord", int'(exp_coord[got]), int'(coord));
				assert (last == exp_last[got])
					else report_mismatch(t_name[row], "o_last", int'(exp_last[got]), int'(last));
				got++;
				cycles = 0;
			end else begin
				cycles++;
			end
			stall = valid && !ready;
			held_coord = coord;
			held_last = last;
			next_cycle();
		end
	endtask

	initial begin
		void'($urandom(55));
		cfg_valid = 1'b0;
		beg = '0;
		fin = '0;
		stride = '0;
		shuf_idx = '0;
		shuf_cnt = '0;
		base = '0;
		ready = 1'b0;
		load_table();
		wait_reset_done();
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		// Controller back in idle after the final walk
		wait_cfg_ready();
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
